/* hw/opb_pkg.sv */
`default_nettype none

package opb_pkg;

  localparam int opb_dwidth  = 32;               // data bus
  localparam int opb_awidth  = 32;               // byte address bus
  localparam int opb_bewidth = 4;                // one enable per byte lane

  localparam int word_lsb   = 2;                 // byte address of a 32-bit word
  localparam int page_lsb   = 24;                // page field starts above the widened address
  localparam int page_width = opb_awidth - page_lsb;

  localparam logic [page_width-1:0] page_regs = 'd0;  // register block
  localparam logic [page_width-1:0] page_bram = 'd1;  // block ram

  localparam logic [1:0] reg_scratch = 2'd0;     // read/write
  localparam logic [1:0] reg_tlimit  = 2'd1;     // read/write, low 16 bits
  localparam logic [1:0] reg_tcount  = 2'd2;     // read only
  localparam logic [1:0] reg_id      = 2'd3;     // read only

  localparam logic [opb_dwidth-1:0] ctrl_id_value = 32'h4550_4201;

  localparam int                      tlimit_width = 16;
  localparam logic [tlimit_width-1:0] tlimit_reset = 16'd16;

endpackage

`default_nettype wire

/* hw/epb_pkg.sv */
`default_nettype none

package epb_pkg;

  localparam int epb_dwidth  = 16;     // host data bus
  localparam int epb_awidth  = 23;     // half-word address from the host
  localparam int epb_gpwidth = 6;      // general purpose address bits
  localparam int epb_bewidth = 2;      // active low byte enables

  localparam int page_bits = 3;        // gp bits used as the opb page

  // address widening: bit 0 picks the half-word, the rest become the word address
  localparam int half_bit      = 0;
  localparam int word_addr_lsb = 1;

endpackage

`default_nettype wire

/* hw/opb_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface opb_if;

  logic                           request;
  logic                           grant;
  logic                           select;
  logic                           rnw;       // high for read
  logic [opb_pkg::opb_bewidth-1:0] be;
  logic [opb_pkg::opb_awidth-1:0]  abus;
  logic [opb_pkg::opb_dwidth-1:0]  wdata;
  logic [opb_pkg::opb_dwidth-1:0]  rdata;     // zero from an unselected slave
  logic                           xfer_ack;
  logic                           err_ack;
  logic                           timeout;

  modport master (
    output request, select, rnw, be, abus, wdata,
    input  grant, rdata, xfer_ack, err_ack, timeout
  );

  modport slave (
    input  request, select, rnw, be, abus, wdata,
    output grant, rdata, xfer_ack, err_ack, timeout
  );

  modport monitor (
    input request, grant, select, rnw, be, abus, wdata,
    input rdata, xfer_ack, err_ack, timeout
  );

endinterface

`default_nettype wire

/* hw/epb_opb_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module epb_opb_bridge (
  input  wire                              OPB_Clk,
  input  wire                              rst_n,
  input  wire                              epb_cs_n,
  input  wire                              epb_r_w_n,
  input  wire                              epb_oe_n,
  input  wire  [epb_pkg::epb_bewidth-1:0]  epb_be_n,
  input  wire  [epb_pkg::epb_awidth-1:0]   epb_addr,
  input  wire  [epb_pkg::epb_gpwidth-1:0]  epb_addr_gp,
  input  wire  [epb_pkg::epb_dwidth-1:0]   epb_data_i,
  output logic [epb_pkg::epb_dwidth-1:0]   epb_data_o,
  output logic                             epb_data_oe_n,
  output logic                             epb_rdy,
  opb_if.master                            opb
);

  localparam int addr_pad = opb_pkg::opb_awidth - opb_pkg::page_lsb - epb_pkg::page_bits;
  localparam int be_pad   = opb_pkg::opb_bewidth - epb_pkg::epb_bewidth;
  localparam int data_pad = opb_pkg::opb_dwidth - epb_pkg::epb_dwidth;

  typedef enum logic [1:0] {
    st_idle,
    st_arb,                                     // request out, waiting for grant
    st_wait                                     // selected, waiting for a reply
  } state_t;

  state_t state;
  logic   prev_cs_n;
  logic   sel_q;
  logic   in_xfer;
  logic   cs_fall;
  logic   reply;
  logic   hi_half;

  assign in_xfer = ~epb_cs_n;
  assign cs_fall = prev_cs_n & ~epb_cs_n;       // start of a host transfer
  assign reply   = opb.xfer_ack | opb.err_ack | opb.timeout;
  assign hi_half = ~epb_addr[epb_pkg::half_bit]; // bit 0 clear is the upper half-word

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_cs_n <= 1'b1;
    end else begin
      prev_cs_n <= epb_cs_n;
    end
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      sel_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (cs_fall) begin
            if (opb.grant) begin
              sel_q <= 1'b1;
              state <= st_wait;
            end else begin
              state <= st_arb;
            end
          end
        end
        st_arb: begin
          if (!in_xfer) begin
            state <= st_idle;                   // host gave up
          end else if (opb.grant) begin
            sel_q <= 1'b1;
            state <= st_wait;
          end
        end
        st_wait: begin
          if (!in_xfer || reply) begin
            sel_q <= 1'b0;
            state <= st_idle;
          end
        end
        default: begin
          sel_q <= 1'b0;
          state <= st_idle;
        end
      endcase
    end
  end

  // request rises with the cs_n edge, select cuts through on the first granted cycle
  assign opb.request = in_xfer & (cs_fall | (state != st_idle));
  assign opb.select  = in_xfer & (sel_q |
                                  (state == st_idle && cs_fall && opb.grant) |
                                  (state == st_arb && opb.grant));

  assign opb.rnw  = opb.select & epb_r_w_n;
  assign opb.abus = opb.select ?
                    {{addr_pad{1'b0}}, epb_addr_gp[epb_pkg::page_bits-1:0],
                     epb_addr[epb_pkg::epb_awidth-1:epb_pkg::word_addr_lsb],
                     {opb_pkg::word_lsb{1'b0}}} : '0;
  assign opb.be    = !opb.select ? '0 :
                     hi_half     ? {~epb_be_n, {be_pad{1'b0}}} :
                                   {{be_pad{1'b0}}, ~epb_be_n};
  assign opb.wdata = !opb.select ? '0 :
                     hi_half     ? {epb_data_i, {data_pad{1'b0}}} :
                                   {{data_pad{1'b0}}, epb_data_i};

  assign epb_rdy       = (state == st_wait) & reply;
  assign epb_data_o    = hi_half ? opb.rdata[opb_pkg::opb_dwidth-1:data_pad] :
                                   opb.rdata[epb_pkg::epb_dwidth-1:0];
  assign epb_data_oe_n = ~epb_r_w_n | epb_cs_n | epb_oe_n;  // drive only on a read

endmodule

`default_nettype wire

/* hw/opb_bus_fabric.sv */
`timescale 1ns/100ps
`default_nettype none

module opb_bus_fabric (
  input  wire   OPB_Clk,
  input  wire   rst_n,
  opb_if.slave  m,
  opb_if.master s_regs,
  opb_if.master s_bram,
  input  wire   timeout                         // from the watchdog
);

  logic                             grant_q;
  logic [opb_pkg::page_width-1:0]   page;

  // single master, so grant just follows request one cycle late
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= 1'b0;
    end else begin
      grant_q <= m.request;
    end
  end

  assign m.grant = grant_q;
  assign page    = m.abus[opb_pkg::opb_awidth-1:opb_pkg::page_lsb];

  assign s_regs.select = m.select & (page == opb_pkg::page_regs);
  assign s_bram.select = m.select & (page == opb_pkg::page_bram);

  assign s_regs.request = m.request;
  assign s_regs.rnw     = m.rnw;
  assign s_regs.be      = m.be;
  assign s_regs.abus    = m.abus;
  assign s_regs.wdata   = m.wdata;

  assign s_bram.request = m.request;
  assign s_bram.rnw     = m.rnw;
  assign s_bram.be      = m.be;
  assign s_bram.abus    = m.abus;
  assign s_bram.wdata   = m.wdata;

  assign m.rdata    = s_regs.rdata | s_bram.rdata;  // idle slaves return zero
  assign m.xfer_ack = s_regs.xfer_ack | s_bram.xfer_ack;
  assign m.err_ack  = s_regs.err_ack | s_bram.err_ack;
  assign m.timeout  = timeout;

endmodule

`default_nettype wire

/* hw/opb_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module opb_ctrl_regs #(
  parameter int TCOUNT_WIDTH = 8
) (
  input  wire                                  OPB_Clk,
  input  wire                                  rst_n,
  opb_if.slave                                 opb,
  input  wire                                  timeout_pulse,
  output logic [opb_pkg::tlimit_width-1:0]     tlimit
);

  logic [opb_pkg::opb_dwidth-1:0]   scratch;
  logic [TCOUNT_WIDTH-1:0]          tcount;
  logic [opb_pkg::opb_dwidth-1:0]   rdata_q;
  logic [opb_pkg::opb_dwidth-1:0]   rd_word;
  logic [1:0]                       offset;
  logic                             sel_q;
  logic                             start;
  logic                             ro_write;
  logic                             ack_q;
  logic                             err_q;

  assign offset   = opb.abus[opb_pkg::word_lsb +: 2];
  assign start    = opb.select & ~sel_q;        // first cycle of a select
  assign ro_write = ~opb.rnw & (offset == opb_pkg::reg_tcount || offset == opb_pkg::reg_id);

  always_comb begin
    case (offset)
      opb_pkg::reg_scratch: rd_word = scratch;
      opb_pkg::reg_tlimit:  rd_word = {{(opb_pkg::opb_dwidth-opb_pkg::tlimit_width){1'b0}}, tlimit};
      opb_pkg::reg_tcount:  rd_word = {{(opb_pkg::opb_dwidth-TCOUNT_WIDTH){1'b0}}, tcount};
      default:              rd_word = opb_pkg::ctrl_id_value;
    endcase
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q   <= 1'b0;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      scratch <= '0;
      tlimit  <= opb_pkg::tlimit_reset;
      tcount  <= '0;
    end else begin
      sel_q <= opb.select;
      ack_q <= start & ~ro_write;
      err_q <= start & ro_write;                // tcount and id refuse writes
      if (start && !opb.rnw && offset == opb_pkg::reg_scratch) begin
        for (int i = 0; i < opb_pkg::opb_bewidth; i++) begin
          if (opb.be[i]) scratch[8*i +: 8] <= opb.wdata[8*i +: 8];
        end
      end
      if (start && !opb.rnw && offset == opb_pkg::reg_tlimit) begin
        for (int i = 0; i < opb_pkg::tlimit_width / 8; i++) begin
          if (opb.be[i]) tlimit[8*i +: 8] <= opb.wdata[8*i +: 8];
        end
      end
      if (timeout_pulse && tcount != '1) tcount <= tcount + 1'b1;  // saturates
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (start) rdata_q <= rd_word;
  end

  assign opb.xfer_ack = ack_q;
  assign opb.err_ack  = err_q;
  assign opb.rdata    = ack_q ? rdata_q : '0;
  assign opb.grant    = 1'b0;                   // slaves never grant or time out
  assign opb.timeout  = 1'b0;

endmodule

`default_nettype wire

/* hw/opb_watchdog.sv */
`timescale 1ns/100ps
`default_nettype none

module opb_watchdog (
  input  wire                               OPB_Clk,
  input  wire                               rst_n,
  opb_if.monitor                            mon,
  input  wire  [opb_pkg::tlimit_width-1:0]  tlimit,
  output logic                              timeout,
  output logic                              timeout_pulse
);

  logic [opb_pkg::tlimit_width-1:0] count;
  logic                             waiting;
  logic                             fire_q;

  assign waiting = mon.select & ~mon.xfer_ack & ~mon.err_ack;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      count  <= '0;
      fire_q <= 1'b0;
    end else begin
      if (!mon.select) begin
        count <= '0;                            // new select starts from zero
      end else if (waiting && count != '1) begin
        count <= count + 1'b1;
      end
      // lands tlimit cycles after select rises, count never revisits this value
      fire_q <= waiting && (count == tlimit - 1'b1);
    end
  end

  assign timeout       = fire_q;
  assign timeout_pulse = fire_q;                // same event, for the tcount register

endmodule

`default_nettype wire

/* hw/opb_bram_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module opb_bram_slave #(
  parameter int BRAM_DEPTH = 256
) (
  input  wire  OPB_Clk,
  input  wire  rst_n,
  opb_if.slave opb
);

  localparam int idx_width = $clog2(BRAM_DEPTH);

  logic [opb_pkg::opb_dwidth-1:0] mem [BRAM_DEPTH];
  logic [opb_pkg::opb_dwidth-1:0] rdata_q;
  logic [idx_width-1:0]           idx;
  logic [1:0]                     ack_pipe;     // one wait state, then ack
  logic                           sel_q;
  logic                           start;

  assign idx   = opb.abus[opb_pkg::word_lsb +: idx_width];
  assign start = opb.select & ~sel_q;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q    <= 1'b0;
      ack_pipe <= '0;
    end else begin
      sel_q    <= opb.select;
      ack_pipe <= opb.select ? {ack_pipe[0], start} : 2'b00;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (start && !opb.rnw) begin
      for (int i = 0; i < opb_pkg::opb_bewidth; i++) begin
        if (opb.be[i]) mem[idx][8*i +: 8] <= opb.wdata[8*i +: 8];
      end
    end
    if (ack_pipe[0]) rdata_q <= mem[idx];       // read in the wait state
  end

  assign opb.xfer_ack = ack_pipe[1];
  assign opb.err_ack  = 1'b0;
  assign opb.rdata    = (ack_pipe[1] && opb.rnw) ? rdata_q : '0;
  assign opb.grant    = 1'b0;
  assign opb.timeout  = 1'b0;

endmodule

`default_nettype wire

/* hw/epb_opb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module epb_opb_top #(
  parameter int BRAM_DEPTH   = 256,
  parameter int TCOUNT_WIDTH = 8
) (
  input  wire                              OPB_Clk,
  input  wire                              rst_n,
  input  wire                              epb_cs_n,
  input  wire                              epb_r_w_n,
  input  wire                              epb_oe_n,
  input  wire  [epb_pkg::epb_bewidth-1:0]  epb_be_n,
  input  wire  [epb_pkg::epb_awidth-1:0]   epb_addr,
  input  wire  [epb_pkg::epb_gpwidth-1:0]  epb_addr_gp,
  input  wire  [epb_pkg::epb_dwidth-1:0]   epb_data_i,
  output logic [epb_pkg::epb_dwidth-1:0]   epb_data_o,
  output logic                             epb_data_oe_n,
  output logic                             epb_rdy
);

  logic                             timeout;
  logic                             timeout_pulse;
  logic [opb_pkg::tlimit_width-1:0] tlimit;

  opb_if m_bus ();                              // bridge to fabric
  opb_if regs_bus ();
  opb_if bram_bus ();

  epb_opb_bridge u_bridge (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .epb_cs_n      (epb_cs_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_oe_n      (epb_oe_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n),
    .epb_rdy       (epb_rdy),
    .opb           (m_bus.master)
  );

  opb_bus_fabric u_fabric (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .m       (m_bus.slave),
    .s_regs  (regs_bus.master),
    .s_bram  (bram_bus.master),
    .timeout (timeout)
  );

  opb_ctrl_regs #(.TCOUNT_WIDTH(TCOUNT_WIDTH)) u_regs (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .opb           (regs_bus.slave),
    .timeout_pulse (timeout_pulse),
    .tlimit        (tlimit)
  );

  opb_watchdog u_watchdog (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .mon           (m_bus.monitor),             // watches the master side
    .tlimit        (tlimit),
    .timeout       (timeout),
    .timeout_pulse (timeout_pulse)
  );

  opb_bram_slave #(.BRAM_DEPTH(BRAM_DEPTH)) u_bram (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .opb     (bram_bus.slave)
  );

endmodule

`default_nettype wire

/* testbench/epb_opb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module epb_opb_checker (
  input wire                              OPB_Clk,
  input wire                              rst_n,
  input wire                              select,
  input wire                              grant,
  input wire                              xfer_ack,
  input wire                              err_ack,
  input wire                              timeout,
  input wire [opb_pkg::opb_bewidth-1:0]   be,
  input wire [opb_pkg::opb_awidth-1:0]    abus
);

  logic reply;
  int   fail_count = 0;

  assign reply = xfer_ack | err_ack | timeout;  // any slave or watchdog answer

  select_needs_grant: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    $rose(select) |-> grant)
    else begin
      fail_count++;
      $error("select rose while grant was low");
    end

  select_drops_after_reply: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    (select && reply) |=> !select)
    else begin
      fail_count++;
      $error("select still high the cycle after a reply");
    end

  idle_bus_zero: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    !select |-> (be == '0 && abus == '0))
    else begin
      fail_count++;
      $error("be or abus nonzero while select is low");
    end

endmodule

bind epb_opb_bridge epb_opb_checker u_checker (
  .OPB_Clk  (OPB_Clk),
  .rst_n    (rst_n),
  .select   (opb.select),
  .grant    (opb.grant),
  .xfer_ack (opb.xfer_ack),
  .err_ack  (opb.err_ack),
  .timeout  (opb.timeout),
  .be       (opb.be),
  .abus     (opb.abus)
);

`default_nettype wire

/* testbench/tb_epb_opb.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_epb_opb;

  localparam int clk_half     = 2;             // 4 ns period
  localparam int drive_delay  = 1;
  localparam int reset_cycles = 2;
  localparam int tlimit_max   = 16;            // largest watchdog limit any trace line runs under
  localparam int max_lines    = 64;
  localparam logic [15:0] tlimit_at_reset = 16'd16;

  logic                             OPB_Clk;
  logic                             rst_n;
  logic                             epb_cs_n;
  logic                             epb_r_w_n;
  logic                             epb_oe_n;
  logic [epb_pkg::epb_bewidth-1:0]  epb_be_n;
  logic [epb_pkg::epb_awidth-1:0]   epb_addr;
  logic [epb_pkg::epb_gpwidth-1:0]  epb_addr_gp;
  logic [epb_pkg::epb_dwidth-1:0]   epb_data_i;
  logic [epb_pkg::epb_dwidth-1:0]   epb_data_o;
  logic                             epb_data_oe_n;
  logic                             epb_rdy;

  int                               tr_test  [max_lines];
  logic                             tr_write [max_lines];
  logic [epb_pkg::epb_gpwidth-1:0]  tr_page  [max_lines];
  logic [epb_pkg::epb_awidth-1:0]   tr_addr  [max_lines];
  logic [epb_pkg::epb_bewidth-1:0]  tr_be_n  [max_lines];
  logic [epb_pkg::epb_dwidth-1:0]   tr_wdata [max_lines];
  logic [epb_pkg::epb_dwidth-1:0]   tr_exp   [max_lines];

  int          n_lines     = 0;
  int          cycles      = 0;
  int          cycle_limit = 1000;              // replaced once the trace is loaded
  int          checks      = 0;
  int          errors      = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  int          bound_fails = 0;
  int          cur_test;
  logic [15:0] model_tlimit = tlimit_at_reset;  // what the watchdog limit should be now

  epb_opb_top dut (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .epb_cs_n      (epb_cs_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_oe_n      (epb_oe_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n),
    .epb_rdy       (epb_rdy)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #clk_half OPB_Clk = ~OPB_Clk;
  end

  always @(posedge OPB_Clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run hung: still waiting for epb_rdy after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // cycles from the cs_n fall to rdy, as the bridge and slave timing give them
  function automatic int expected_latency(input logic [epb_pkg::epb_gpwidth-1:0] page,
                                          input logic [15:0] limit);
    if (page[epb_pkg::page_bits-1:0] == 3'd0) return 2;   // register block acks after one cycle
    if (page[epb_pkg::page_bits-1:0] == 3'd1) return 3;   // block ram adds one wait state
    return 1 + int'(limit);                                // unmapped page answered by the watchdog
  endfunction

  task automatic load_trace();
    int          fd;
    int          code;
    int          t;
    byte         kind;
    logic [31:0] pg, ad, be, wd, ex;
    string       line;
    fd = $fopen("testbench/epb_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/epb_trace.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && n_lines < max_lines) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%d %c %h %h %h %h %h", t, kind, pg, ad, be, wd, ex);
      if (code != 7) begin
        $display("trace line could not be read: %s", line);
        errors++;
        continue;
      end
      tr_test[n_lines]  = t;
      tr_write[n_lines] = (kind == "W");
      tr_page[n_lines]  = pg[epb_pkg::epb_gpwidth-1:0];
      tr_addr[n_lines]  = ad[epb_pkg::epb_awidth-1:0];
      tr_be_n[n_lines]  = be[epb_pkg::epb_bewidth-1:0];
      tr_wdata[n_lines] = wd[epb_pkg::epb_dwidth-1:0];
      tr_exp[n_lines]   = ex[epb_pkg::epb_dwidth-1:0];
      n_lines++;
    end
    $fclose(fd);
  endtask

  task automatic run_transfer(input int i);
    int                             wait_cycles;
    int                             exp_lat;
    int unsigned                    gap;
    logic [epb_pkg::epb_dwidth-1:0] got;
    logic                           oe_n_rdy;
    exp_lat = expected_latency(tr_page[i], model_tlimit);
    gap     = 2 + ($urandom % 4);               // idle cycles before the next transfer
    @(posedge OPB_Clk);
    #drive_delay;
    epb_addr_gp = tr_page[i];
    epb_addr    = tr_addr[i];
    epb_be_n    = tr_be_n[i];
    epb_r_w_n   = ~tr_write[i];
    epb_oe_n    = tr_write[i];
    epb_data_i  = tr_wdata[i];
    epb_cs_n    = 1'b0;
    wait_cycles = 0;
    @(negedge OPB_Clk);
    while (!epb_rdy) begin
      wait_cycles++;
      @(negedge OPB_Clk);
    end
    got      = epb_data_o;                      // sampled mid-cycle while rdy is high
    oe_n_rdy = epb_data_oe_n;
    @(posedge OPB_Clk);
    #drive_delay;
    epb_cs_n  = 1'b1;
    epb_oe_n  = 1'b1;
    epb_r_w_n = 1'b1;
    checks += 2;
    assert (wait_cycles == exp_lat) else begin
      $display("[ERROR] %0t ns: line %0d rdy after %0d cycles, expected %0d",
               $time, i, wait_cycles, exp_lat);
      errors++;
    end
    assert (oe_n_rdy == tr_write[i]) else begin
      $display("[ERROR] %0t ns: line %0d epb_data_oe_n %b at rdy, expected %b",
               $time, i, oe_n_rdy, tr_write[i]);
      errors++;
    end
    if (!tr_write[i]) begin
      checks++;
      assert (got == tr_exp[i]) else begin
        $display("[ERROR] %0t ns: line %0d read 0x%h, expected 0x%h", $time, i, got, tr_exp[i]);
        errors++;
      end
    end
    // a low half-word write to the tlimit word moves the watchdog limit
    if (tr_write[i] && tr_page[i][epb_pkg::page_bits-1:0] == '0 &&
        tr_addr[i][2:1] == 2'd1 && tr_addr[i][0]) begin
      if (!tr_be_n[i][0]) model_tlimit[7:0] = tr_wdata[i][7:0];
      if (!tr_be_n[i][1]) model_tlimit[15:8] = tr_wdata[i][15:8];
    end
    repeat (gap) @(posedge OPB_Clk);
  endtask

  task automatic report_test(input int t);
    $display("test %0d done: %0d checks, %0d errors", t, checks - test_checks,
             errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial begin
    void'($urandom(32'h7a2b909c));
    rst_n       = 1'b0;
    epb_cs_n    = 1'b1;
    epb_r_w_n   = 1'b1;
    epb_oe_n    = 1'b1;
    epb_be_n    = '1;
    epb_addr    = '0;
    epb_addr_gp = '0;
    epb_data_i  = '0;
    load_trace();
    cycle_limit = reset_cycles + 4 + n_lines * (tlimit_max + 10);
    if (n_lines == 0) begin
      $display("trace holds no transfers");
      errors++;
    end
    repeat (reset_cycles) @(posedge OPB_Clk);
    #drive_delay;
    rst_n       = 1'b1;
    test_errors = errors;
    cur_test    = (n_lines > 0) ? tr_test[0] : 0;
    for (int i = 0; i < n_lines; i++) begin
      if (tr_test[i] != cur_test) begin
        report_test(cur_test);
        cur_test = tr_test[i];
      end
      run_transfer(i);
    end
    if (n_lines > 0) report_test(cur_test);
    bound_fails = dut.u_bridge.u_checker.fail_count;
    if (bound_fails != 0) begin
      $display("bridge OPB side assertions failed %0d times", bound_fails);
      errors += bound_fails;
    end
    $display("%0d transfers, %0d checks, %0d errors", n_lines, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/epb_trace.txt */
# test  W/R  page  epb_addr  be_n  wdata  expected_rdata   (all but test and W/R in hex)
# be_n bit 1 gates data bits 15:8, bit 0 gates bits 7:0; expected is ignored on writes
1 R 0 000006 0 0000 4550
1 R 0 000007 0 0000 4201
2 W 0 000000 0 1234 0000
2 W 0 000001 0 5678 0000
2 W 0 000000 2 ABCD 0000
2 R 0 000000 0 0000 12CD
2 W 0 000001 1 9A00 0000
2 R 0 000001 0 0000 9A78
3 W 1 000000 0 CAFE 0000
3 W 1 000043 0 1357 0000
3 W 1 0001FE 0 2468 0000
3 R 1 000000 0 0000 CAFE
3 R 1 000043 0 0000 1357
3 R 1 0001FE 0 0000 2468
4 W 0 000006 0 FFFF 0000
4 R 0 000006 0 0000 4550
4 R 0 000007 0 0000 4201
5 W 0 000003 0 0006 0000
5 R 0 000003 0 0000 0006
5 R 0 000005 0 0000 0000
5 W 5 000010 0 1111 0000
5 R 5 000010 0 0000 0000
5 R 0 000005 0 0000 0002

/* files.f */
hw/opb_pkg.sv
hw/epb_pkg.sv
hw/opb_if.sv
hw/epb_opb_bridge.sv
hw/opb_bus_fabric.sv
hw/opb_ctrl_regs.sv
hw/opb_watchdog.sv
hw/opb_bram_slave.sv
hw/epb_opb_top.sv
testbench/epb_opb_checker.sv
testbench/tb_epb_opb.sv

/* run_sim.sh */
#!/bin/sh
# build the EPB to OPB testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_epb_opb \
  -f files.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
